// ==== common/dz_pkg.sv ====
package dz_pkg;

    // matrix geometry
    localparam int dz_rows = 8;

    // glyph frame number, 12..15 are blank
    typedef logic [3:0] frame_t;

    // row index, 0 is the top row
    typedef logic [2:0] row_idx_t;

    // one column word, bit 7 is the leftmost LED, 1 = lit
    typedef logic [7:0] col_t;

    // both colour planes of one row
    typedef struct packed {
        col_t red;
        col_t green;
    } dz_color_t;

    // registered matrix drive
    typedef struct packed {
        logic [dz_rows-1:0] row_sel;  // active low, one bit low when lit
        dz_color_t          color;
    } dz_drive_t;

    // heat disc animation runs over frames 0..anim_last
    localparam frame_t anim_last = 4'd5;

endpackage

// ==== hdl/scan_tick_gen.sv ====
`timescale 1ns/1ps

module scan_tick_gen #(
    parameter int SCAN_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick
);

    localparam int CW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CW-1:0] cnt;

    // down counter, reload at zero
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= CW'(SCAN_DIV - 1);
            scan_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt       <= CW'(SCAN_DIV - 1);
            scan_tick <= 1'b1;  // one row period elapsed
        end
        else
        begin
            cnt       <= cnt - 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

// ==== hdl/frame_seq.sv ====
`timescale 1ns/1ps

module frame_seq #(
    parameter int ANIM_SCANS = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           st,
    input  logic           anim,
    input  dz_pkg::frame_t req_frame,
    input  logic           frame_done,
    output dz_pkg::frame_t frame
);
    import dz_pkg::*;

    localparam int SW = (ANIM_SCANS > 1) ? $clog2(ANIM_SCANS) : 1;

    logic [SW-1:0] scan_cnt;   // full scans shown of the current anim frame
    logic          anim_prev;
    logic          anim_entry;
    logic          step;

    assign anim_entry = anim & ~anim_prev;
    assign step       = frame_done & (scan_cnt == SW'(ANIM_SCANS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame     <= '0;
            scan_cnt  <= '0;
            anim_prev <= 1'b0;
        end
        else
        begin
            anim_prev <= anim;
            if (!st || anim_entry)
            begin
                // display off or animation just started
                frame    <= '0;
                scan_cnt <= '0;
            end
            else if (!anim)
            begin
                frame    <= req_frame;
                scan_cnt <= '0;
            end
            else if (step)
            begin
                scan_cnt <= '0;
                frame    <= (frame >= anim_last) ? '0 : frame + 1'b1;
            end
            else if (frame_done)
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // once a cycle in anim mode has passed, only heat disc frames are shown
    a_anim_range: assert property (@(posedge clk) disable iff (rst)
        anim_prev |-> frame <= anim_last);

endmodule

// ==== dz_show/dz_glyph_rom.sv ====
`timescale 1ns/1ps

module dz_glyph_rom (
    input  dz_pkg::frame_t    frame,
    input  dz_pkg::row_idx_t  row_idx,
    input  logic              temp,
    output dz_pkg::dz_color_t row_color
);
    import dz_pkg::*;

    col_t green;
    col_t red;

    always_comb
    begin
        green = '0;
        case (frame)
            4'd0:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = 8'b0000_0000;
                endcase
            end
            4'd1:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = 8'b0000_0000;
                endcase
            end
            4'd2:
            begin
                case (row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = 8'b0000_0000;
                endcase
            end
            4'd3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = 8'b0000_0000;
                endcase
            end
            4'd4:
            begin
                case (row_idx)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            end
            4'd5: green = 8'b1111_1111;  // full disc
            4'd6:
            begin
                case (row_idx)
                    3'd0: green = 8'b1100_0011;
                    3'd1: green = 8'b1110_0011;
                    3'd2: green = 8'b1111_0001;
                    3'd3: green = 8'b1110_0011;
                    3'd4: green = 8'b1100_0111;
                    3'd5: green = 8'b1110_0111;
                    3'd6: green = 8'b1111_0111;
                    3'd7: green = 8'b1111_1011;
                endcase
            end
            4'd7:
            begin
                case (row_idx)
                    3'd1:    green = 8'b0000_0001;
                    3'd2:    green = 8'b1000_0001;
                    3'd3:    green = 8'b1100_0011;
                    3'd4:    green = 8'b1000_0011;
                    3'd5:    green = 8'b1100_0111;
                    3'd6:    green = 8'b1110_0111;
                    3'd7:    green = 8'b1111_0011;
                    default: green = 8'b0000_0000;
                endcase
            end
            4'd8:
            begin
                case (row_idx)
                    3'd1:    green = 8'b0011_1000;
                    3'd2:    green = 8'b0100_0100;
                    3'd3:    green = 8'b0101_1010;
                    3'd4:    green = 8'b0100_1010;
                    3'd5:    green = 8'b0011_0010;
                    3'd6:    green = 8'b1100_0100;
                    3'd7:    green = 8'b0011_1000;
                    default: green = 8'b0000_0000;
                endcase
            end
            4'd9:
            begin
                case (row_idx)
                    3'd2:    green = 8'b0110_0000;
                    3'd3:    green = 8'b1111_1100;
                    3'd4:    green = 8'b0011_1111;
                    3'd5:    green = 8'b0011_1110;
                    3'd6:    green = 8'b0001_1100;
                    default: green = 8'b0000_0000;
                endcase
            end
            4'd10:
            begin
                case (row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = 8'b0000_0000;
                endcase
            end
            4'd11:
            begin
                case (row_idx)
                    3'd0: green = 8'b1110_0000;
                    3'd1: green = 8'b0110_0000;
                    3'd2: green = 8'b1110_0000;
                    3'd3: green = 8'b0011_0000;
                    3'd4: green = 8'b0011_0001;
                    3'd5: green = 8'b0011_0011;
                    3'd6: green = 8'b0011_1110;
                    3'd7: green = 8'b0001_1100;
                endcase
            end
            default: green = 8'b0000_0000;  // blank frames
        endcase
    end

    // red plane, amber = red and green together
    always_comb
    begin
        case (frame)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
                red = temp ? green : 8'b0000_0000;  // heat disc goes amber
            4'd6, 4'd7, 4'd8, 4'd9, 4'd11:
                red = green;
            default:
                red = 8'b0000_0000;  // frame 10 stays green
        endcase
    end

    assign row_color.red   = red;
    assign row_color.green = green;

endmodule

// ==== dz_show/dz_scan.sv ====
`timescale 1ns/1ps

module dz_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  logic              scan_tick,
    input  dz_pkg::dz_color_t row_color,
    output dz_pkg::row_idx_t  row_idx,
    output logic              frame_done,
    output dz_pkg::dz_drive_t drive
);
    import dz_pkg::*;

    localparam row_idx_t  last_row   = row_idx_t'(dz_rows - 1);
    localparam dz_drive_t drive_idle = '{row_sel: '1, color: '0};

    logic [dz_rows-1:0] row_sel_d;
    logic               load;

    assign load       = scan_tick & st;
    assign frame_done = load & (row_idx == last_row);  // strobe that loads the last row

    // row index to active-low select
    always_comb
    begin
        for (int i = 0; i < dz_rows; i++)
            row_sel_d[i] = (row_idx != row_idx_t'(i));
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            drive   <= drive_idle;
        end
        else if (!st)
        begin
            // blank and restart at the top row
            row_idx <= '0;
            drive   <= drive_idle;
        end
        else if (load)
        begin
            drive.row_sel <= row_sel_d;
            drive.color   <= row_color;
            row_idx       <= row_idx + 1'b1;  // wraps after last row
        end
    end

    // never more than one row lit
    a_row_sel_single: assert property (@(posedge clk) disable iff (rst)
        $onehot0(~drive.row_sel));

    // frame_done marks the strobe whose load lights the bottom row
    a_frame_done_row: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> scan_tick ##1 drive.row_sel == {1'b0, {(dz_rows - 1){1'b1}}});

endmodule

// ==== hdl/dz_top.sv ====
`timescale 1ns/1ps

module dz_top #(
    parameter int SCAN_DIV   = 4,   // clocks per row
    parameter int ANIM_SCANS = 2    // full scans per animation step
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  logic              temp,
    input  logic              anim,
    input  dz_pkg::frame_t    req_frame,
    output dz_pkg::dz_drive_t drive
);
    import dz_pkg::*;

    logic      scan_tick;
    logic      frame_done;
    row_idx_t  row_idx;
    frame_t    frame;
    dz_color_t row_color;

    scan_tick_gen #(
        .SCAN_DIV   (SCAN_DIV)
    ) scan_tick_gen_inst (
        .clk        (clk),
        .rst        (rst),
        .scan_tick  (scan_tick)
    );

    frame_seq #(
        .ANIM_SCANS (ANIM_SCANS)
    ) frame_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .anim       (anim),
        .req_frame  (req_frame),
        .frame_done (frame_done),
        .frame      (frame)
    );

    dz_glyph_rom dz_glyph_rom_inst (
        .frame      (frame),
        .row_idx    (row_idx),
        .temp       (temp),
        .row_color  (row_color)
    );

    dz_scan dz_scan_inst (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .scan_tick  (scan_tick),
        .row_color  (row_color),
        .row_idx    (row_idx),
        .frame_done (frame_done),
        .drive      (drive)
    );

endmodule

// ==== verif/tb_dz_top.sv ====
`timescale 1ns/1ps

module tb_dz_top;
    import dz_pkg::*;

    localparam int SCAN_DIV     = 4;
    localparam int ANIM_SCANS   = 2;
    localparam int ROW0_LIMIT   = 2 * dz_rows * SCAN_DIV + 4;
    localparam int STROBE_LIMIT = SCAN_DIV + 2;
    localparam int NUM_FIXED    = 25;
    localparam int NUM_RAND     = 8;
    localparam int NUM_STIM     = NUM_FIXED + NUM_RAND;

    localparam dz_drive_t drive_idle = '{row_sel: '1, color: '0};

    // green rows of each frame with row 0 in the top byte
    localparam logic [63:0] glyph [16] = '{
        64'h0000_183C_3C18_0000,    // heat disc 0
        64'h0000_387C_7C38_0000,
        64'h0000_3C7E_7E3C_0000,
        64'h003C_7E7E_7E7E_3C00,
        64'h3C7E_FFFF_FFFF_7E3C,
        64'hFFFF_FFFF_FFFF_FFFF,    // heat disc 5
        64'hC3E3_F1E3_C7E7_F7FB,
        64'h0001_81C3_83C7_E7F3,
        64'h0038_445A_4A32_C438,
        64'h0000_60FC_3F3E_1C00,
        64'h0000_183C_7E7E_2400,
        64'hE060_E030_3133_3E1C,
        64'h0, 64'h0, 64'h0, 64'h0  // blank
    };

    typedef struct packed {
        logic       st;
        logic       temp;
        logic       anim;
        frame_t     req;
        logic [3:0] scans;  // full scans to hold
        logic [2:0] rows;   // extra strobes after the scans
    } stim_t;

    logic      clk;
    logic      rst;
    logic      st;
    logic      temp;
    logic      anim;
    frame_t    req_frame;
    dz_drive_t drive;

    stim_t stim [NUM_STIM];

    // reference state
    int        m_div;
    logic      m_tick;
    row_idx_t  m_row;
    frame_t    m_frame;
    int        m_scans;
    logic      m_anim_prev;
    dz_drive_t exp_drive;
    logic      strobe_seen;
    logic      row0_seen;

    int checks;
    int errors;
    int timeouts;

    dz_top dz_top_inst (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp      (temp),
        .anim      (anim),
        .req_frame (req_frame),
        .drive     (drive)
    );

    always #50 clk = ~clk;

    function automatic col_t glyph_green(input frame_t f, input row_idx_t r);
        logic [63:0] w;
        w = glyph[f];
        return col_t'(w >> (8 * (dz_rows - 1 - int'(r))));
    endfunction

    function automatic col_t red_of(input frame_t f, input col_t g, input logic t);
        if (f <= anim_last)
            return t ? g : 8'h00;   // amber only when hot
        else if (f == 4'd10 || f >= 4'd12)
            return 8'h00;
        else
            return g;
    endfunction

    function automatic stim_t make_entry(input logic s, input logic t, input logic a,
                                         input frame_t f, input int sc, input int rw);
        stim_t e;
        e.st    = s;
        e.temp  = t;
        e.anim  = a;
        e.req   = f;
        e.scans = 4'(sc);
        e.rows  = 3'(rw);
        return e;
    endfunction

    task automatic build_table();
        stim[0]  = make_entry(1'b0, 1'b0, 1'b0, 4'd0, 1, 0);    // display off
        stim[1]  = make_entry(1'b1, 1'b0, 1'b0, 4'd0, 2, 0);
        stim[2]  = make_entry(1'b1, 1'b1, 1'b0, 4'd0, 1, 0);
        stim[3]  = make_entry(1'b1, 1'b0, 1'b0, 4'd4, 2, 0);
        stim[4]  = make_entry(1'b1, 1'b1, 1'b0, 4'd4, 1, 0);
        stim[5]  = make_entry(1'b1, 1'b1, 1'b0, 4'd5, 1, 0);
        stim[6]  = make_entry(1'b1, 1'b0, 1'b0, 4'd6, 1, 0);
        stim[7]  = make_entry(1'b1, 1'b1, 1'b0, 4'd6, 1, 0);
        stim[8]  = make_entry(1'b1, 1'b0, 1'b0, 4'd7, 1, 0);
        stim[9]  = make_entry(1'b1, 1'b1, 1'b0, 4'd8, 1, 0);
        stim[10] = make_entry(1'b1, 1'b0, 1'b0, 4'd9, 1, 0);
        stim[11] = make_entry(1'b1, 1'b1, 1'b0, 4'd10, 1, 0);  // green only
        stim[12] = make_entry(1'b1, 1'b0, 1'b0, 4'd11, 1, 0);
        stim[13] = make_entry(1'b1, 1'b1, 1'b0, 4'd12, 1, 0);
        stim[14] = make_entry(1'b1, 1'b0, 1'b0, 4'd15, 1, 0);
        stim[15] = make_entry(1'b1, 1'b0, 1'b1, 4'd0, 14, 0);  // full animation and wrap
        stim[16] = make_entry(1'b1, 1'b1, 1'b1, 4'd0, 3, 3);
        stim[17] = make_entry(1'b0, 1'b1, 1'b1, 4'd0, 1, 0);   // drop st mid scan
        stim[18] = make_entry(1'b1, 1'b0, 1'b1, 4'd0, 4, 0);
        stim[19] = make_entry(1'b1, 1'b1, 1'b0, 4'd3, 1, 5);
        stim[20] = make_entry(1'b0, 1'b1, 1'b0, 4'd3, 1, 0);
        stim[21] = make_entry(1'b1, 1'b1, 1'b0, 4'd7, 1, 0);   // icons with the other temp
        stim[22] = make_entry(1'b1, 1'b0, 1'b0, 4'd8, 1, 0);
        stim[23] = make_entry(1'b1, 1'b1, 1'b0, 4'd9, 1, 0);
        stim[24] = make_entry(1'b1, 1'b1, 1'b0, 4'd11, 1, 0);
        for (int i = NUM_FIXED; i < NUM_STIM; i++)
            stim[i] = make_entry(1'b1, 1'($urandom % 2), 1'b0, 4'($urandom % 16), 1, 0);
    endtask

    task automatic reset_model();
        m_div       = SCAN_DIV - 1;
        m_tick      = 1'b0;
        m_row       = '0;
        m_frame     = '0;
        m_scans     = 0;
        m_anim_prev = 1'b0;
        exp_drive   = drive_idle;
        strobe_seen = 1'b0;
        row0_seen   = 1'b0;
    endtask

    task automatic check_drive();
        checks++;
        if (drive !== exp_drive)
        begin
            errors++;
            $display("MISMATCH at %0t: sel %b red %h green %h, expected sel %b red %h green %h",
                     $time, drive.row_sel, drive.color.red, drive.color.green,
                     exp_drive.row_sel, exp_drive.color.red, exp_drive.color.green);
        end
    endtask

    // one clock of the reference and a compare once drive has settled
    task automatic clock_step();
        logic load;
        logic done;
        logic anim_entry;
        col_t g;
        @(posedge clk);
        load        = m_tick & st;
        done        = load & (m_row == 3'd7);
        anim_entry  = anim & ~m_anim_prev;
        strobe_seen = m_tick;
        row0_seen   = load & (m_row == 3'd0);
        if (!st)
        begin
            exp_drive = drive_idle;
            m_row     = '0;
        end
        else if (load)
        begin
            g = glyph_green(m_frame, m_row);
            exp_drive.row_sel     = ~(8'b1 << m_row);
            exp_drive.color.green = g;
            exp_drive.color.red   = red_of(m_frame, g, temp);
            m_row = m_row + 3'd1;
        end
        if (!st || anim_entry)
        begin
            m_frame = 4'd0;
            m_scans = 0;
        end
        else if (!anim)
        begin
            m_frame = req_frame;
            m_scans = 0;
        end
        else if (done)
        begin
            if (m_scans == ANIM_SCANS - 1)
            begin
                m_scans = 0;
                m_frame = (m_frame >= anim_last) ? 4'd0 : m_frame + 4'd1;
            end
            else
                m_scans++;
        end
        m_anim_prev = anim;
        if (m_div == 0)
        begin
            m_div  = SCAN_DIV - 1;
            m_tick = 1'b1;
        end
        else
        begin
            m_div--;
            m_tick = 1'b0;
        end
        #1;
        check_drive();
    endtask

    task automatic wait_row0_load(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < ROW0_LIMIT)
        begin
            clock_step();
            n++;
            if (row0_seen)
                ok = 1'b1;
        end
    endtask

    task automatic wait_strobes(input int count, output bit ok);
        int n;
        int seen;
        n    = 0;
        seen = 0;
        while (seen < count && n < count * STROBE_LIMIT)
        begin
            clock_step();
            n++;
            if (strobe_seen)
                seen++;
        end
        ok = (seen == count);
    endtask

    initial
    begin
        int unsigned seed;
        stim_t       cur;
        bit          ok;
        int          i;
        int          s;
        seed      = $urandom(32'hb1cd);
        clk       = 1'b0;
        rst       = 1'b1;
        st        = 1'b0;
        temp      = 1'b0;
        anim      = 1'b0;
        req_frame = '0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        reset_model();
        build_table();
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_drive();  // idle during reset
        end
        rst = 1'b0;
        for (i = 0; i < NUM_STIM && timeouts == 0; i++)
        begin
            cur       = stim[i];
            st        = cur.st;
            temp      = cur.temp;
            anim      = cur.anim;
            req_frame = cur.req;
            for (s = 0; s < int'(cur.scans) && timeouts == 0; s++)
            begin
                if (cur.st)
                    wait_row0_load(ok);
                else
                    wait_strobes(dz_rows, ok);
                if (!ok)
                begin
                    timeouts++;
                    $display("timeout: scan did not come round in entry %0d at %0t", i, $time);
                end
            end
            if (timeouts == 0 && cur.rows != 3'd0)
            begin
                wait_strobes(int'(cur.rows), ok);
                if (!ok)
                begin
                    timeouts++;
                    $display("timeout: row strobes missing in entry %0d at %0t", i, $time);
                end
            end
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== build.f ====
common/dz_pkg.sv
hdl/scan_tick_gen.sv
hdl/frame_seq.sv
dz_show/dz_glyph_rom.sv
dz_show/dz_scan.sv
hdl/dz_top.sv
verif/tb_dz_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dz_top
FILELIST  = build.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
